//--- Bender.yml
package:
  name: sd_dat_rx

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/sd_dat_pkg.sv
      - src/sd_dat_deserializer.sv
      - src/sd_crc16_lanes.sv
      - src/sd_dat_read_fsm.sv
      - src/sd_dat_rx.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/sd_dat_rx_checker.sv
      - tests/sd_dat_rx_tb.sv

//--- all.f
+incdir+include
src/sd_dat_pkg.sv
src/sd_dat_deserializer.sv
src/sd_crc16_lanes.sv
src/sd_dat_read_fsm.sv
src/sd_dat_rx.sv
tests/sd_dat_rx_checker.sv
tests/sd_dat_rx_tb.sv

//--- include/sd_dat_defs.svh
`ifndef SD_DAT_DEFS_SVH
`define SD_DAT_DEFS_SVH

// Data word handed to the host
`define SD_WORD_W 32

// 512-byte block as 32-bit words
`define SD_BLOCK_WORDS 128

// DAT0 to DAT3
`define SD_LANES 4

// CRC-16 per lane, appended after the block data
`define SD_CRC_W 16

// SD clocks kept running after the last block
`define SD_TAIL_CYCLES 8

`endif

//--- src/sd_crc16_lanes.sv
`include "sd_dat_defs.svh"

module sd_crc16_lanes (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 clkstrb_i,
    input  sd_dat_pkg::dp_ctrl_t dp_ctrl_i,
    input  logic                 d4_i,
    input  logic [`SD_LANES-1:0] sd_dat_i,
    output logic                 crc_nonzero_o
);

    // x^16 + x^12 + x^5 + 1
    localparam logic [`SD_CRC_W-1:0] CRC_POLY = 16'h1021;

    logic [`SD_LANES-1:0] lane_nonzero;
    logic [`SD_LANES-1:0] lane_active;

    for (genvar l = 0; l < `SD_LANES; l++) begin : g_lane
        logic [`SD_CRC_W-1:0] crc_q;
        logic                 feedback;

        assign feedback = sd_dat_i[l] ^ crc_q[`SD_CRC_W-1];

        // Data and CRC bits both go through, a good block leaves zero
        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                crc_q <= '0;
            end else if (clkstrb_i) begin
                if (dp_ctrl_i.crc_clear) begin
                    crc_q <= '0;
                end else if (dp_ctrl_i.shift) begin
                    crc_q <= {crc_q[`SD_CRC_W-2:0], 1'b0} ^ ({`SD_CRC_W{feedback}} & CRC_POLY);
                end
            end
        end

        assign lane_nonzero[l] = |crc_q;
    end

    // Only DAT0 counts in 1-line mode
    assign lane_active = {{(`SD_LANES-1){d4_i}}, 1'b1};

    assign crc_nonzero_o = |(lane_nonzero & lane_active);

endmodule

//--- src/sd_dat_deserializer.sv
`include "sd_dat_defs.svh"

module sd_dat_deserializer (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  clkstrb_i,
    input  sd_dat_pkg::dp_ctrl_t  dp_ctrl_i,
    input  logic                  d4_i,
    input  logic [`SD_LANES-1:0]  sd_dat_i,
    output logic [`SD_WORD_W-1:0] dat_o
);

    localparam int BYTES = `SD_WORD_W / 8;

    logic [`SD_WORD_W-1:0] shreg_q;
    logic [`SD_WORD_W-1:0] shreg_d;

    // DAT3 lands in the most significant position of each nibble
    always_comb begin
        if (d4_i) begin
            shreg_d = {shreg_q[`SD_WORD_W-`SD_LANES-1:0], sd_dat_i};
        end else begin
            shreg_d = {shreg_q[`SD_WORD_W-2:0], sd_dat_i[0]};
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            shreg_q <= '0;
        end else if (clkstrb_i) begin
            if (dp_ctrl_i.reg_clear) begin
                shreg_q <= '0;
            end else if (dp_ctrl_i.shift) begin
                shreg_q <= shreg_d;
            end
        end
    end

    // First received byte ends up in the low byte for the host
    for (genvar i = 0; i < BYTES; i++) begin : g_swap
        assign dat_o[i*8 +: 8] = shreg_q[(BYTES-1-i)*8 +: 8];
    end

endmodule

//--- src/sd_dat_pkg.sv
package sd_dat_pkg;

    // Receive sequencer states, IDLE must stay at zero
    typedef enum logic [2:0] {
        IDLE,
        WAIT_BLOCK,
        READ_BLOCK,
        REGOUT,
        READ_CRC,
        READ_FINISH,
        TAIL
    } state_e;

    // Host requests
    typedef struct packed {
        logic start;
        logic dat_ack;
        logic last_block;
        logic d4;
    } ctrl_t;

    // Reported back to the host
    typedef struct packed {
        logic idle;
        logic data;
        logic block_done;
        logic crc_ok;
    } status_t;

    // Sequencer to shift register and CRC lanes
    typedef struct packed {
        logic shift;
        logic crc_clear;
        logic reg_clear;
    } dp_ctrl_t;

endpackage

//--- src/sd_dat_read_fsm.sv
`include "sd_dat_defs.svh"

module sd_dat_read_fsm (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 clkstrb_i,
    input  logic                 fsm_rst_i,
    input  sd_dat_pkg::ctrl_t    ctrl_i,
    input  logic                 sd_clk_en_i,
    input  logic                 dat0_i,
    input  logic                 crc_nonzero_i,
    output sd_dat_pkg::dp_ctrl_t dp_ctrl_o,
    output sd_dat_pkg::status_t  status_o,
    output logic                 sd_clk_req_o,
    output logic                 sd_clk_stall_o
);

    localparam logic [5:0] LAST_BIT_1L = 6'(`SD_WORD_W - 1);
    localparam logic [5:0] LAST_BIT_4L = 6'(`SD_WORD_W / `SD_LANES - 1);
    localparam logic [5:0] LAST_CRC    = 6'(`SD_CRC_W - 1);
    localparam logic [5:0] LAST_TAIL   = 6'(`SD_TAIL_CYCLES - 1);
    localparam logic [7:0] BLOCK_WORDS = 8'(`SD_BLOCK_WORDS);

    typedef struct packed {
        sd_dat_pkg::state_e state;
        logic [5:0]         bit_cnt;
        logic [7:0]         word_cnt;
        logic               clk_req;
        logic               clk_stall;
        logic               shift_en;
        logic               crc_clear;
        logic               reg_clear;
        logic               crc_ok;
        logic               block_done;
    } fsm_regs_t;

    fsm_regs_t  q;
    fsm_regs_t  d;
    logic [5:0] word_last;

    assign word_last = ctrl_i.d4 ? LAST_BIT_4L : LAST_BIT_1L;

    always_comb begin
        d = q;
        // One strobe pulse
        d.block_done = 1'b0;

        case (q.state)
            sd_dat_pkg::IDLE: begin
                if (ctrl_i.start) begin
                    d.clk_req   = 1'b1;
                    d.shift_en  = 1'b1;
                    d.crc_clear = 1'b1;
                    d.reg_clear = 1'b0;
                    d.state     = sd_dat_pkg::WAIT_BLOCK;
                end
            end
            sd_dat_pkg::WAIT_BLOCK: begin
                // Start bit on DAT0
                if (sd_clk_en_i && !dat0_i) begin
                    d.crc_clear = 1'b0;
                    d.bit_cnt   = '0;
                    d.word_cnt  = '0;
                    d.state     = sd_dat_pkg::READ_BLOCK;
                end
            end
            sd_dat_pkg::READ_BLOCK: begin
                if (sd_clk_en_i) begin
                    if (q.bit_cnt == word_last) begin
                        d.bit_cnt   = '0;
                        d.word_cnt  = q.word_cnt + 8'd1;
                        d.clk_stall = 1'b1;
                        d.state     = sd_dat_pkg::REGOUT;
                    end else begin
                        d.bit_cnt = q.bit_cnt + 6'd1;
                    end
                end
            end
            sd_dat_pkg::REGOUT: begin
                // Card clock stays stopped until the host takes the word
                if (ctrl_i.dat_ack) begin
                    d.clk_stall = 1'b0;
                    d.bit_cnt   = '0;
                    if (q.word_cnt == BLOCK_WORDS) begin
                        d.state = sd_dat_pkg::READ_CRC;
                    end else begin
                        d.state = sd_dat_pkg::READ_BLOCK;
                    end
                end
            end
            sd_dat_pkg::READ_CRC: begin
                if (sd_clk_en_i) begin
                    if (q.bit_cnt == LAST_CRC) begin
                        d.clk_stall = 1'b1;
                        d.reg_clear = 1'b1;
                        d.state     = sd_dat_pkg::READ_FINISH;
                    end else begin
                        d.bit_cnt = q.bit_cnt + 6'd1;
                    end
                end
            end
            sd_dat_pkg::READ_FINISH: begin
                // Remainder is still in the lanes here
                d.crc_ok     = !crc_nonzero_i;
                d.block_done = 1'b1;
                d.bit_cnt    = '0;
                d.crc_clear  = 1'b1;
                d.reg_clear  = 1'b0;
                d.clk_stall  = 1'b0;
                d.state      = sd_dat_pkg::WAIT_BLOCK;
            end
            sd_dat_pkg::TAIL: begin
                if (sd_clk_en_i) begin
                    if (q.bit_cnt == LAST_TAIL) begin
                        d.clk_req = 1'b0;
                        d.state   = sd_dat_pkg::IDLE;
                    end else begin
                        d.bit_cnt = q.bit_cnt + 6'd1;
                    end
                end
            end
            default: begin
                d.state = sd_dat_pkg::IDLE;
            end
        endcase

        // Last block request wins over everything above
        if (ctrl_i.last_block && q.state != sd_dat_pkg::IDLE && q.state != sd_dat_pkg::TAIL) begin
            d.shift_en  = 1'b0;
            d.crc_clear = 1'b1;
            d.reg_clear = 1'b1;
            d.clk_stall = 1'b0;
            d.bit_cnt   = '0;
            d.state     = sd_dat_pkg::TAIL;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            q <= '0;
        end else if (clkstrb_i) begin
            if (fsm_rst_i) begin
                q <= '0;
            end else begin
                q <= d;
            end
        end
    end

    assign status_o.idle       = (q.state == sd_dat_pkg::IDLE);
    assign status_o.data       = (q.state == sd_dat_pkg::REGOUT);
    assign status_o.block_done = q.block_done;
    assign status_o.crc_ok     = q.crc_ok;

    // Only bit periods where the SD clock really ticks
    assign dp_ctrl_o.shift     = q.shift_en & sd_clk_en_i;
    assign dp_ctrl_o.crc_clear = q.crc_clear;
    assign dp_ctrl_o.reg_clear = q.reg_clear;

    assign sd_clk_req_o   = q.clk_req;
    assign sd_clk_stall_o = q.clk_stall;

endmodule

//--- src/sd_dat_rx.sv
`include "sd_dat_defs.svh"

module sd_dat_rx (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  clkstrb_i,
    input  logic                  fsm_rst_i,
    input  sd_dat_pkg::ctrl_t     ctrl_i,
    input  logic                  sd_clk_en_i,
    input  logic [`SD_LANES-1:0]  sd_dat_i,
    output logic [`SD_WORD_W-1:0] dat_o,
    output sd_dat_pkg::status_t   status_o,
    output logic                  sd_clk_req_o,
    output logic                  sd_clk_stall_o
);

    sd_dat_pkg::dp_ctrl_t dp_ctrl;
    logic                 crc_nonzero;

    sd_dat_read_fsm u_fsm (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .clkstrb_i      (clkstrb_i),
        .fsm_rst_i      (fsm_rst_i),
        .ctrl_i         (ctrl_i),
        .sd_clk_en_i    (sd_clk_en_i),
        .dat0_i         (sd_dat_i[0]),
        .crc_nonzero_i  (crc_nonzero),
        .dp_ctrl_o      (dp_ctrl),
        .status_o       (status_o),
        .sd_clk_req_o   (sd_clk_req_o),
        .sd_clk_stall_o (sd_clk_stall_o)
    );

    sd_dat_deserializer u_deser (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .clkstrb_i (clkstrb_i),
        .dp_ctrl_i (dp_ctrl),
        .d4_i      (ctrl_i.d4),
        .sd_dat_i  (sd_dat_i),
        .dat_o     (dat_o)
    );

    sd_crc16_lanes u_crc (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .clkstrb_i     (clkstrb_i),
        .dp_ctrl_i     (dp_ctrl),
        .d4_i          (ctrl_i.d4),
        .sd_dat_i      (sd_dat_i),
        .crc_nonzero_o (crc_nonzero)
    );

endmodule

//--- tests/sd_dat_rx_checker.sv
module sd_dat_rx_checker (
    input logic                clk_i,
    input logic                rstn_i,
    input logic                clkstrb_i,
    input sd_dat_pkg::status_t status_i,
    input logic                sd_clk_req_i,
    input logic                sd_clk_stall_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // A word on dat_o always has the card clock stopped
    a_data_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
        status_i.data |-> sd_clk_stall_i)
        else $error("data word shown while the SD clock runs");

    // Gone again after the next strobe
    a_done_fall: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (clkstrb_i && status_i.block_done) |=> !status_i.block_done)
        else $error("block_done held longer than one strobe period");

    a_idle_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        status_i.idle |-> !sd_clk_req_i)
        else $error("SD clock requested while idle");

endmodule

//--- tests/sd_dat_rx_tb.sv
`include "sd_dat_defs.svh"

module sd_dat_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 2000;
    // Bit order of ctrl_t is start, dat_ack, last_block, d4
    localparam logic [3:0] CTRL_START = 4'b1000;
    localparam logic [3:0] CTRL_ACK   = 4'b0100;
    localparam logic [3:0] CTRL_LAST  = 4'b0010;
    // Bit order of status_t is idle, data, block_done, crc_ok
    localparam logic [3:0] WAIT_IDLE  = 4'b1000;
    localparam logic [3:0] WAIT_DATA  = 4'b0100;
    localparam logic [3:0] WAIT_DONE  = 4'b0010;

    logic                  clk_i = 1'b0;
    logic                  rstn_i;
    logic                  clkstrb_i;
    logic                  fsm_rst_i;
    sd_dat_pkg::ctrl_t     ctrl_i;
    logic                  sd_clk_en_i;
    logic [`SD_LANES-1:0]  sd_dat_i;
    logic [`SD_WORD_W-1:0] dat_o;
    sd_dat_pkg::status_t   status_o;
    logic                  sd_clk_req_o;
    logic                  sd_clk_stall_o;

    logic [31:0] lfsr = 32'h93f9_fc74;
    logic [3:0]  card_q[$];
    logic [31:0] exp_q[$];
    int          errors = 0;
    int          tests_run = 0;
    int          failed_tests = 0;
    int          test_start_err;

    sd_dat_rx UUT (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .clkstrb_i      (clkstrb_i),
        .fsm_rst_i      (fsm_rst_i),
        .ctrl_i         (ctrl_i),
        .sd_clk_en_i    (sd_clk_en_i),
        .sd_dat_i       (sd_dat_i),
        .dat_o          (dat_o),
        .status_o       (status_o),
        .sd_clk_req_o   (sd_clk_req_o),
        .sd_clk_stall_o (sd_clk_stall_o)
    );

    bind sd_dat_rx sd_dat_rx_checker u_checker (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .clkstrb_i      (clkstrb_i),
        .status_i       (status_o),
        .sd_clk_req_i   (sd_clk_req_o),
        .sd_clk_stall_i (sd_clk_stall_o)
    );

    always #5 clk_i = ~clk_i;

    // Strobe every second cycle, the card moves on after each enabled strobe
    always @(negedge clk_i) begin
        if (clkstrb_i && sd_clk_en_i && card_q.size() > 0) begin
            void'(card_q.pop_front());
        end
        clkstrb_i   <= !clkstrb_i;
        sd_clk_en_i <= !clkstrb_i && sd_clk_req_o && !sd_clk_stall_o;
        sd_dat_i    <= (card_q.size() > 0) ? card_q[0] : 4'hF;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // CRC-16-CCITT, x^16 + x^12 + x^5 + 1, MSB first
    function automatic logic [15:0] crc16_bit(input logic [15:0] crc, input logic b);
        logic fb;
        fb  = b ^ crc[15];
        crc = {crc[14:0], 1'b0};
        return fb ? (crc ^ 16'h1021) : crc;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_start_err) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, errors - test_start_err);
        end
    endtask

    // Card stream: idle, start bit, data per lane, lane CRCs, end bit
    task automatic load_block(input bit d4, input bit corrupt);
        logic [7:0]  blk [4*`SD_BLOCK_WORDS];
        logic [15:0] crc [`SD_LANES];
        logic [3:0]  nib;
        int          n;
        int          bad_lane;
        int          bad_bit;
        n = d4 ? 4 : 1;
        bad_lane = -1;
        bad_bit = -1;
        for (int l = 0; l < `SD_LANES; l++) begin
            crc[l] = '0;
        end
        for (int i = 0; i < 4 * `SD_BLOCK_WORDS; i++) begin
            blk[i] = 8'(rand_bits(8));
        end
        card_q.push_back(4'hF);
        card_q.push_back(4'hF);
        card_q.push_back(d4 ? 4'h0 : 4'hE);
        for (int i = 0; i < 4 * `SD_BLOCK_WORDS; i++) begin
            for (int s = 0; s < 8 / n; s++) begin
                nib = 4'hF;
                for (int l = 0; l < n; l++) begin
                    nib[l] = blk[i][8 - (s + 1) * n + l];
                    crc[l] = crc16_bit(crc[l], nib[l]);
                end
                card_q.push_back(nib);
            end
        end
        if (corrupt) begin
            bad_lane = rand_bits(2) % n;
            bad_bit = rand_bits(4);
        end
        for (int b = `SD_CRC_W - 1; b >= 0; b--) begin
            nib = 4'hF;
            for (int l = 0; l < n; l++) begin
                nib[l] = crc[l][b] ^ (l == bad_lane && b == bad_bit);
            end
            card_q.push_back(nib);
        end
        card_q.push_back(4'hF);
        for (int w = 0; w < `SD_BLOCK_WORDS; w++) begin
            exp_q.push_back({blk[4*w+3], blk[4*w+2], blk[4*w+1], blk[4*w]});
        end
    endtask

    // Two clock cycles span exactly one strobe
    task automatic pulse_ctrl(input logic [3:0] mask);
        ctrl_i <= sd_dat_pkg::ctrl_t'(ctrl_i | mask);
        repeat (2) @(negedge clk_i);
        ctrl_i <= sd_dat_pkg::ctrl_t'(ctrl_i & ~mask);
    endtask

    task automatic wait_status(input logic [3:0] mask, input string what,
                               output bit ok, output int en_cnt);
        ok = 1'b0;
        en_cnt = 0;
        for (int i = 0; i < TIMEOUT && !ok; i++) begin
            @(negedge clk_i);
            if (clkstrb_i && sd_clk_en_i) begin
                en_cnt++;
            end
            ok = |(status_o & mask);
        end
        if (!ok) begin
            $display("Timeout at %0d ns: %s never came", $time, what);
            errors++;
        end
    endtask

    task automatic receive_words(input int count, input bit hold_off, output bit ok);
        logic [31:0] exp;
        int          delay;
        int          en_cnt;
        ok = 1'b1;
        for (int w = 0; w < count && ok; w++) begin
            wait_status(WAIT_DATA, "a data word", ok, en_cnt);
            if (ok) begin
                exp = exp_q.pop_front();
                if (dat_o !== exp) begin
                    report_mismatch($sformatf("word %0d is %h, expected %h", w, dat_o, exp));
                end
                delay = hold_off ? rand_bits(5) % 21 : 0;
                repeat (2 * delay) begin
                    @(negedge clk_i);
                    if (!status_o.data || !sd_clk_stall_o) begin
                        report_mismatch("word or stall dropped before the acknowledge");
                    end
                end
                pulse_ctrl(CTRL_ACK);
            end
        end
    endtask

    task automatic stop_transfer(output bit ok, output int tail);
        pulse_ctrl(CTRL_LAST);
        wait_status(WAIT_IDLE, "idle after last_block", ok, tail);
        card_q.delete();
        exp_q.delete();
    endtask

    task automatic read_blocks(input bit d4, input bit corrupt, input int blocks,
                               input bit hold_off);
        bit ok;
        int en_cnt;
        ok = 1'b1;
        ctrl_i.d4 <= d4;
        for (int b = 0; b < blocks; b++) begin
            load_block(d4, corrupt);
        end
        @(negedge clk_i);
        pulse_ctrl(CTRL_START);
        for (int b = 0; b < blocks && ok; b++) begin
            receive_words(`SD_BLOCK_WORDS, hold_off, ok);
            if (ok) begin
                wait_status(WAIT_DONE, "block_done", ok, en_cnt);
            end
            if (ok && status_o.crc_ok !== !corrupt) begin
                report_mismatch($sformatf("block %0d crc_ok is %b", b, status_o.crc_ok));
            end
        end
        stop_transfer(ok, en_cnt);
    endtask

    initial begin
        bit ok;
        int tail;
        int en_cnt;
        rstn_i = 1'b0;
        clkstrb_i = 1'b0;
        fsm_rst_i = 1'b0;
        ctrl_i = '0;
        sd_clk_en_i = 1'b0;
        sd_dat_i = '1;
        repeat (8) @(negedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);

        test_start_err = errors;
        if (status_o !== 4'b1000 || sd_clk_req_o !== 1'b0 || sd_clk_stall_o !== 1'b0) begin
            report_mismatch($sformatf("after reset status is %b", status_o));
        end
        end_test("reset values");

        test_start_err = errors;
        read_blocks(1'b0, 1'b0, 1, 1'b0);
        end_test("1-line read");

        test_start_err = errors;
        read_blocks(1'b1, 1'b0, 1, 1'b0);
        end_test("4-line read");

        test_start_err = errors;
        read_blocks(1'b1, 1'b1, 1, 1'b0);
        end_test("corrupt CRC");

        test_start_err = errors;
        read_blocks(1'b1, 1'b0, 2, 1'b1);
        end_test("back-pressure");

        // No card data, so the DUT keeps waiting for a start bit
        test_start_err = errors;
        pulse_ctrl(CTRL_START);
        repeat (10) @(negedge clk_i);
        if (status_o.idle !== 1'b0) begin
            report_mismatch("still idle after start");
        end
        stop_transfer(ok, tail);
        if (ok && (tail != `SD_TAIL_CYCLES || sd_clk_req_o !== 1'b0)) begin
            report_mismatch($sformatf("tail of %0d clocks, clk_req %b", tail, sd_clk_req_o));
        end
        end_test("abort while waiting");

        // Still in 4-line mode here
        test_start_err = errors;
        load_block(1'b1, 1'b0);
        pulse_ctrl(CTRL_START);
        receive_words(10, 1'b0, ok);
        // Next word left unacknowledged, so data and stall are high at the reset
        wait_status(WAIT_DATA, "a data word", ok, en_cnt);
        fsm_rst_i <= 1'b1;
        repeat (2) @(negedge clk_i);
        fsm_rst_i <= 1'b0;
        if (status_o !== 4'b1000 || sd_clk_stall_o !== 1'b0 || sd_clk_req_o !== 1'b0) begin
            report_mismatch($sformatf("after soft reset status is %b", status_o));
        end
        card_q.delete();
        exp_q.delete();
        end_test("soft reset");

        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
